// ==== verilog/fpga_defines.svh ====
// Front-end command constants

`ifndef FPGA_DEFINES_SVH
`define FPGA_DEFINES_SVH

// --------------------------------------------------
// Host command word
// --------------------------------------------------

// Width of one command word shifted in over the host link
`define FPGA_CMD_W 16

// Opcode that loads the configuration byte
`define FPGA_OP_CONF 4'd1

// Opcode that loads the ADC clock divisor
`define FPGA_OP_DIV 4'd2

// --------------------------------------------------
// Reset values
// --------------------------------------------------

// Divisor in use until the host writes its own
// The ADC clock then runs at ncs / 192
`define FPGA_DIV_RESET 8'd95

`endif

// ==== verilog/fpga_pkg.sv ====
// Front-end shared types

package fpga_pkg;

	// --------------------------------------------------
	// Major modes
	// --------------------------------------------------

	// Only two modes have logic behind them
	// Any code not listed here switches every pin off
	typedef enum logic [2:0]
	{
		mode_lo_read    = 3'b000,
		mode_hi_read_tx = 3'b010,
		mode_off        = 3'b111
	} major_mode_e;

	// Configuration byte as the host writes it
	// Bit 3 picks the 125 kHz setting of the low-frequency reader
	// Bit 0 picks shallow modulation in the high-frequency transmitter
	typedef struct packed
	{
		major_mode_e major_mode;
		logic        spare_hi;
		logic        lo_is_125khz;
		logic [1:0]  spare_lo;
		logic        shallow_mod;
	} conf_word_t;

	// --------------------------------------------------
	// Command word views
	// --------------------------------------------------

	// Configuration command with the byte in the low half
	typedef struct packed
	{
		logic [3:0] opcode;
		logic [3:0] spare;
		conf_word_t conf;
	} conf_cmd_t;

	// Divisor command with the divisor in the low half
	typedef struct packed
	{
		logic [3:0] opcode;
		logic [3:0] spare;
		logic [7:0] divisor;
	} div_cmd_t;

	// One shifted word, read through whichever view its opcode names
	typedef union packed
	{
		conf_cmd_t conf;
		div_cmd_t  div;
	} cmd_word_u;

endpackage

// ==== verilog/mode_pins_if.sv ====
// Mode block pin bundle

interface mode_pins_if;

	// Antenna drivers
	logic pwr_lo;
	logic pwr_hi;
	logic pwr_oe1;
	logic pwr_oe2;
	logic pwr_oe3;
	logic pwr_oe4;

	// Clock for the external ADC
	logic adc_clk;

	// Synchronous serial port towards the host
	logic ssp_frame;
	logic ssp_din;
	logic ssp_clk;

	// Spare pin for a scope probe
	logic dbg;

	// A mode block drives the whole set
	modport src (output pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
		adc_clk, ssp_frame, ssp_din, ssp_clk, dbg);

	// The mode multiplexer only looks at it
	modport sink (input pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
		adc_clk, ssp_frame, ssp_din, ssp_clk, dbg);

endinterface

// ==== verilog/spi_conf_rx.sv ====
// Host command receiver

`include "fpga_defines.svh"

module spi_conf_rx
	import fpga_pkg::*;
(
	input  logic       ncs,
	input  logic       reset,
	input  logic       spi_clk,
	input  logic       spi_sel_n,
	input  logic       mosi,
	output conf_word_t conf,
	output logic [7:0] divisor
);

	// Two synchroniser stages plus one history stage for edge detection
	logic [2:0] clk_sync_q;
	logic [2:0] sel_sync_q;
	logic [1:0] mosi_sync_q;
	logic       clk_rise;
	logic       sel_rise;
	logic       apply_q;
	logic       cmd_vld_q;
	cmd_word_u  shift_q;
	cmd_word_u  cmd_q;
	conf_word_t conf_q;
	logic [7:0] divisor_q;

	// --------------------------------------------------
	// Link synchroniser
	// --------------------------------------------------

	always_ff @(posedge ncs)
	begin
		if (reset)
		begin
			clk_sync_q  <= 3'b000;
			sel_sync_q  <= 3'b111;
			mosi_sync_q <= 2'b00;
		end
		else
		begin
			clk_sync_q  <= {clk_sync_q[1:0], spi_clk};
			sel_sync_q  <= {sel_sync_q[1:0], spi_sel_n};
			mosi_sync_q <= {mosi_sync_q[0], mosi};
		end
	end

	// Data goes through as many stages as the clock so the two stay aligned
	assign clk_rise = clk_sync_q[1] & ~clk_sync_q[2];
	assign sel_rise = sel_sync_q[1] & ~sel_sync_q[2];

	// MSB arrives first and walks up the word
	always_ff @(posedge ncs)
	begin
		if (clk_rise && !sel_sync_q[1])
			shift_q <= {shift_q[`FPGA_CMD_W-2:0], mosi_sync_q[1]};
	end

	// --------------------------------------------------
	// Apply and decode
	// --------------------------------------------------

	// The word is copied out of the shifter a cycle after the select rises
	// so a following word can start shifting straight away
	always_ff @(posedge ncs)
	begin
		if (reset)
		begin
			apply_q   <= 1'b0;
			cmd_vld_q <= 1'b0;
		end
		else
		begin
			apply_q   <= sel_rise;
			cmd_vld_q <= apply_q;
		end
	end

	always_ff @(posedge ncs)
	begin
		if (apply_q)
			cmd_q <= shift_q;
	end

	// The opcode decides which view of the held word is valid
	// Unknown opcodes leave both registers alone
	always_ff @(posedge ncs)
	begin
		if (reset)
		begin
			conf_q    <= '{major_mode: mode_off, spare_hi: 1'b0, lo_is_125khz: 1'b0,
				spare_lo: 2'b00, shallow_mod: 1'b0};
			divisor_q <= `FPGA_DIV_RESET;
		end
		else if (cmd_vld_q)
		begin
			case (cmd_q.conf.opcode)
				`FPGA_OP_CONF: conf_q <= cmd_q.conf.conf;
				`FPGA_OP_DIV:  divisor_q <= cmd_q.div.divisor;
				default: ;
			endcase
		end
	end

	assign conf    = conf_q;
	assign divisor = divisor_q;

endmodule

// ==== verilog/lo_read.sv ====
// Low-frequency reader

module lo_read
(
	input  logic        ncs,
	input  logic        reset,
	input  logic [7:0]  adc_d,
	input  logic        lo_is_125khz,
	input  logic [7:0]  divisor,
	mode_pins_if.src    pins
);

	logic [7:0] div_cnt_q;
	logic       adc_clk_q;
	logic       adc_fall;
	logic [7:0] shift_q;
	logic [2:0] bit_cnt_q;
	logic       phase_q;
	logic       busy_q;

	// --------------------------------------------------
	// ADC clock divider
	// --------------------------------------------------

	// Each half period lasts divisor+1 cycles
	// Comparing with >= keeps the count sane when the divisor shrinks mid-count
	assign adc_fall = adc_clk_q && (div_cnt_q >= divisor);

	always_ff @(posedge ncs)
	begin
		if (reset)
		begin
			div_cnt_q <= 8'd0;
			adc_clk_q <= 1'b0;
		end
		else if (div_cnt_q >= divisor)
		begin
			div_cnt_q <= 8'd0;
			adc_clk_q <= ~adc_clk_q;
		end
		else
			div_cnt_q <= div_cnt_q + 8'd1;
	end

	// --------------------------------------------------
	// Serial port byte transmitter
	// --------------------------------------------------

	// Every bit takes two cycles, low phase first, then high phase
	// A sample that arrives while a byte is still going out is lost
	always_ff @(posedge ncs)
	begin
		if (reset)
		begin
			busy_q    <= 1'b0;
			phase_q   <= 1'b0;
			bit_cnt_q <= 3'd0;
		end
		else if (!busy_q)
		begin
			if (adc_fall)
			begin
				busy_q    <= 1'b1;
				phase_q   <= 1'b0;
				bit_cnt_q <= 3'd0;
			end
		end
		else if (!phase_q)
			phase_q <= 1'b1;
		else
		begin
			phase_q <= 1'b0;
			if (bit_cnt_q == 3'd7)
				busy_q <= 1'b0;
			else
				bit_cnt_q <= bit_cnt_q + 3'd1;
		end
	end

	// The sample is taken on the falling ADC clock edge itself
	always_ff @(posedge ncs)
	begin
		if (!busy_q && adc_fall)
			shift_q <= adc_d;
		else if (busy_q && phase_q)
			shift_q <= {shift_q[6:0], 1'b0};
	end

	assign pins.ssp_clk   = busy_q & phase_q;
	assign pins.ssp_din   = busy_q & shift_q[7];
	assign pins.ssp_frame = busy_q && (bit_cnt_q == 3'd0);

	// The low-frequency coil follows the ADC clock
	assign pins.adc_clk = adc_clk_q;
	assign pins.pwr_lo  = adc_clk_q;
	assign pins.pwr_hi  = 1'b0;
	assign pins.pwr_oe1 = 1'b0;
	assign pins.pwr_oe2 = 1'b0;
	assign pins.pwr_oe3 = 1'b0;
	assign pins.pwr_oe4 = 1'b0;
	assign pins.dbg     = lo_is_125khz;

endmodule

// ==== verilog/hi_read_tx.sv ====
// High-frequency reader transmitter

module hi_read_tx
(
	input  logic     ncs,
	input  logic     reset,
	input  logic     ssp_dout,
	input  logic     shallow_mod,
	mode_pins_if.src pins
);

	logic carrier_q;
	logic kill_carrier;
	logic shallow_on;

	// --------------------------------------------------
	// Carrier
	// --------------------------------------------------

	// Half the system clock drives the high-frequency coil
	always_ff @(posedge ncs)
	begin
		if (reset)
			carrier_q <= 1'b0;
		else
			carrier_q <= ~carrier_q;
	end

	// --------------------------------------------------
	// Modulation
	// --------------------------------------------------

	// Full depth simply stops driving the coil for a high data bit
	assign kill_carrier = ssp_dout & ~shallow_mod;

	// Shallow depth keeps the carrier and switches on the first two
	// output enables, so only part of the drive changes
	assign shallow_on = ssp_dout & shallow_mod;

	assign pins.pwr_hi  = carrier_q & ~kill_carrier;
	assign pins.pwr_oe1 = shallow_on;
	assign pins.pwr_oe2 = shallow_on;
	assign pins.pwr_oe3 = 1'b0;
	assign pins.pwr_oe4 = 1'b0;
	assign pins.pwr_lo  = 1'b0;

	// The ADC is clocked from the carrier as it goes out
	assign pins.adc_clk = carrier_q & ~kill_carrier;

	// Nothing is sent back to the host in this mode
	assign pins.ssp_clk   = 1'b0;
	assign pins.ssp_frame = 1'b0;
	assign pins.ssp_din   = 1'b0;

	// Probe shows the raw host data
	assign pins.dbg = ssp_dout;

endmodule

// ==== verilog/mode_mux.sv ====
// Output pin multiplexer

module mode_mux
	import fpga_pkg::*;
(
	input  major_mode_e major_mode,
	mode_pins_if.sink   lr,
	mode_pins_if.sink   ht,
	output logic        pwr_lo,
	output logic        pwr_hi,
	output logic        pwr_oe1,
	output logic        pwr_oe2,
	output logic        pwr_oe3,
	output logic        pwr_oe4,
	output logic        adc_clk,
	output logic        ssp_frame,
	output logic        ssp_din,
	output logic        ssp_clk,
	output logic        dbg
);

	// The pins go to the block of the active mode
	// Every other code, mode_off included, keeps the board quiet
	always_comb
	begin
		case (major_mode)
			mode_lo_read:
			begin
				{pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4} =
					{lr.pwr_lo, lr.pwr_hi, lr.pwr_oe1, lr.pwr_oe2, lr.pwr_oe3, lr.pwr_oe4};
				{adc_clk, ssp_frame, ssp_din, ssp_clk, dbg} =
					{lr.adc_clk, lr.ssp_frame, lr.ssp_din, lr.ssp_clk, lr.dbg};
			end
			mode_hi_read_tx:
			begin
				{pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4} =
					{ht.pwr_lo, ht.pwr_hi, ht.pwr_oe1, ht.pwr_oe2, ht.pwr_oe3, ht.pwr_oe4};
				{adc_clk, ssp_frame, ssp_din, ssp_clk, dbg} =
					{ht.adc_clk, ht.ssp_frame, ht.ssp_din, ht.ssp_clk, ht.dbg};
			end
			default:
			begin
				{pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4} = 6'b000000;
				{adc_clk, ssp_frame, ssp_din, ssp_clk, dbg} = 5'b00000;
			end
		endcase
	end

endmodule

// ==== verilog/fpga.sv ====
// RFID front-end top level

module fpga
	import fpga_pkg::*;
(
	input  logic       ncs,
	input  logic       reset,
	input  logic       spi_clk,
	input  logic       spi_sel_n,
	input  logic       mosi,
	input  logic [7:0] adc_d,
	input  logic       ssp_dout,
	output logic       pwr_lo,
	output logic       pwr_hi,
	output logic       pwr_oe1,
	output logic       pwr_oe2,
	output logic       pwr_oe3,
	output logic       pwr_oe4,
	output logic       adc_clk,
	output logic       adc_noe,
	output logic       ssp_frame,
	output logic       ssp_din,
	output logic       ssp_clk,
	output logic       dbg
);

	conf_word_t conf;
	logic [7:0] divisor;

	// One pin set for each mode block
	mode_pins_if lr_pins ();
	mode_pins_if ht_pins ();

	// --------------------------------------------------
	// Host configuration
	// --------------------------------------------------

	spi_conf_rx conf_rx_i (
		.ncs       (ncs),
		.reset     (reset),
		.spi_clk   (spi_clk),
		.spi_sel_n (spi_sel_n),
		.mosi      (mosi),
		.conf      (conf),
		.divisor   (divisor)
	);

	// --------------------------------------------------
	// Mode blocks
	// --------------------------------------------------

	// Both blocks run all the time and the multiplexer picks one
	lo_read lr_i (
		.ncs          (ncs),
		.reset        (reset),
		.adc_d        (adc_d),
		.lo_is_125khz (conf.lo_is_125khz),
		.divisor      (divisor),
		.pins         (lr_pins)
	);

	hi_read_tx ht_i (
		.ncs         (ncs),
		.reset       (reset),
		.ssp_dout    (ssp_dout),
		.shallow_mod (conf.shallow_mod),
		.pins        (ht_pins)
	);

	mode_mux mux_i (
		.major_mode (conf.major_mode),
		.lr         (lr_pins),
		.ht         (ht_pins),
		.pwr_lo     (pwr_lo),
		.pwr_hi     (pwr_hi),
		.pwr_oe1    (pwr_oe1),
		.pwr_oe2    (pwr_oe2),
		.pwr_oe3    (pwr_oe3),
		.pwr_oe4    (pwr_oe4),
		.adc_clk    (adc_clk),
		.ssp_frame  (ssp_frame),
		.ssp_din    (ssp_din),
		.ssp_clk    (ssp_clk),
		.dbg        (dbg)
	);

	// ADC outputs stay enabled in every mode
	assign adc_noe = 1'b0;

endmodule

// ==== dv/fpga_tb.sv ====
// RFID front-end testbench

`include "fpga_defines.svh"

module fpga_tb
	import fpga_pkg::*;
();

	// Cycles any single wait may take before the run is abandoned
	localparam int wait_limit = 600;

	// Bit positions in the 11-pin output vector
	localparam logic [10:0] hi_mask  = 11'b01000000000;
	localparam logic [10:0] oe1_mask = 11'b00100000000;

	logic ncs;
	logic reset;
	logic spi_clk;
	logic spi_sel_n;
	logic mosi;
	logic [7:0] adc_d;
	logic ssp_dout;
	logic pwr_lo;
	logic pwr_hi;
	logic pwr_oe1;
	logic pwr_oe2;
	logic pwr_oe3;
	logic pwr_oe4;
	logic adc_clk;
	logic adc_noe;
	logic ssp_frame;
	logic ssp_din;
	logic ssp_clk;
	logic dbg;
	int unsigned rnd;
	int cyc = 0;

	fpga dut_i (
		.ncs       (ncs),
		.reset     (reset),
		.spi_clk   (spi_clk),
		.spi_sel_n (spi_sel_n),
		.mosi      (mosi),
		.adc_d     (adc_d),
		.ssp_dout  (ssp_dout),
		.pwr_lo    (pwr_lo),
		.pwr_hi    (pwr_hi),
		.pwr_oe1   (pwr_oe1),
		.pwr_oe2   (pwr_oe2),
		.pwr_oe3   (pwr_oe3),
		.pwr_oe4   (pwr_oe4),
		.adc_clk   (adc_clk),
		.adc_noe   (adc_noe),
		.ssp_frame (ssp_frame),
		.ssp_din   (ssp_din),
		.ssp_clk   (ssp_clk),
		.dbg       (dbg)
	);

	initial
	begin
		ncs = 1'b0;
		forever #2 ncs = ~ncs;
	end

	// Free-running cycle count, read only on falling edges
	always @(posedge ncs)
	begin
		cyc <= cyc + 1;
	end

	// --------------------------------------------------
	// Checking helpers
	// --------------------------------------------------

	function automatic logic [10:0] pin_vec();
		return {pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4,
			adc_clk, ssp_frame, ssp_din, ssp_clk, dbg};
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s expected %02h actual %02h", name, exp, act));
	endtask

	task automatic check_pins(input string name, input logic [10:0] exp, input logic [10:0] act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s expected %011b actual %011b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
	endtask

	// --------------------------------------------------
	// Host link driver
	// --------------------------------------------------

	function automatic cmd_word_u make_conf(input major_mode_e mode, input logic lo125,
		input logic shallow);
		cmd_word_u w;
		w = '0;
		w.conf.opcode = `FPGA_OP_CONF;
		w.conf.conf.major_mode = mode;
		w.conf.conf.lo_is_125khz = lo125;
		w.conf.conf.shallow_mod = shallow;
		return w;
	endfunction

	function automatic cmd_word_u make_div(input logic [7:0] div);
		cmd_word_u w;
		w = '0;
		w.div.opcode = `FPGA_OP_DIV;
		w.div.divisor = div;
		return w;
	endfunction

	// Each link half period spans three system cycles so the synchroniser sees every edge
	// The select stays high for a short gap after the word
	task automatic send_cmd(input cmd_word_u cmd);
		logic [`FPGA_CMD_W-1:0] bits;
		int i;
		bits = cmd;
		@(posedge ncs);
		spi_sel_n <= 1'b0;
		for (i = `FPGA_CMD_W - 1; i >= 0; i--)
		begin
			@(posedge ncs);
			mosi <= bits[i];
			spi_clk <= 1'b0;
			repeat (3) @(posedge ncs);
			spi_clk <= 1'b1;
			repeat (3) @(posedge ncs);
		end
		spi_sel_n <= 1'b1;
		spi_clk <= 1'b0;
		repeat (8) @(posedge ncs);
	endtask

	// --------------------------------------------------
	// Waits on the outputs
	// --------------------------------------------------

	task automatic wait_pins(input string name, input logic [10:0] mask,
		input logic [10:0] value);
		int n;
		n = 0;
		@(negedge ncs);
		while ((pin_vec() & mask) !== value)
		begin
			n++;
			if (n > wait_limit)
				stop_run($sformatf("%s timed out waiting for the output pins", name));
			@(negedge ncs);
		end
	endtask

	// Returns on the falling edge where ssp_frame is first seen high
	task automatic wait_frame_start(input string name, output int start);
		logic prev;
		int n;
		n = 0;
		@(negedge ncs);
		prev = ssp_frame;
		@(negedge ncs);
		while (!(ssp_frame && !prev))
		begin
			n++;
			if (n > wait_limit)
				stop_run($sformatf("%s timed out waiting for a serial port frame", name));
			prev = ssp_frame;
			@(negedge ncs);
		end
		start = cyc;
	endtask

	// One bit is taken at every rising ssp_clk, MSB first
	task automatic read_ssp_byte(input string name, output logic [7:0] data);
		logic prev;
		int i;
		int n;
		data = 8'h00;
		prev = ssp_clk;
		for (i = 0; i < 8; i++)
		begin
			n = 0;
			@(negedge ncs);
			while (!(ssp_clk && !prev))
			begin
				n++;
				if (n > wait_limit)
					stop_run($sformatf("%s timed out waiting for ssp_clk", name));
				prev = ssp_clk;
				@(negedge ncs);
			end
			prev = ssp_clk;
			data = {data[6:0], ssp_din};
		end
	endtask

	// Carrier toggles every cycle and adc_clk follows it
	task automatic check_carrier(input string name, input logic oe12, input logic dbg_exp,
		input int cycles);
		logic hi;
		@(negedge ncs);
		hi = pwr_hi;
		repeat (cycles)
		begin
			@(negedge ncs);
			hi = ~hi;
			check_pins(name, {1'b0, hi, oe12, oe12, 2'b00, hi, 3'b000, dbg_exp}, pin_vec());
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------

	task automatic test_after_reset();
		repeat (20)
		begin
			@(negedge ncs);
			check_pins("after reset", 11'b0, pin_vec());
			check_count("after reset adc_noe", 0, int'(adc_noe));
		end
	endtask

	// Falling ADC clock edges come every 2 * (divisor + 1) cycles
	task automatic test_lo_sampling();
		logic [7:0] sample;
		logic [7:0] got;
		int start_prev;
		int start;
		int k;
		rnd = $urandom;
		sample = rnd[7:0];
		@(posedge ncs);
		adc_d <= sample;
		send_cmd(make_div(8'd20));
		send_cmd(make_conf(mode_lo_read, 1'b1, 1'b0));
		wait_frame_start("lo sampling", start_prev);
		read_ssp_byte("lo sampling", got);
		check_byte("lo sampling byte", sample, got);
		// The probe pin carries the 125 kHz setting in this mode
		check_count("lo sampling dbg", 1, int'(dbg));
		for (k = 0; k < 2; k++)
		begin
			wait_frame_start("lo sampling", start);
			check_count("lo sampling frame spacing", 42, start - start_prev);
			read_ssp_byte("lo sampling", got);
			check_byte("lo sampling byte", sample, got);
			start_prev = start;
		end
	endtask

	task automatic test_divisor_change();
		logic prev;
		int n;
		int high;
		send_cmd(make_div(8'd30));
		n = 0;
		@(negedge ncs);
		prev = adc_clk;
		@(negedge ncs);
		while (!(adc_clk && !prev))
		begin
			n++;
			if (n > wait_limit)
				stop_run("divisor change timed out waiting for adc_clk to rise");
			prev = adc_clk;
			@(negedge ncs);
		end
		high = 0;
		while (adc_clk)
		begin
			high++;
			if (high > wait_limit)
				stop_run("divisor change timed out waiting for adc_clk to fall");
			check_count("divisor change pwr_lo", 1, int'(pwr_lo));
			@(negedge ncs);
		end
		check_count("divisor change high time", 31, high);
	endtask

	task automatic test_full_mod();
		@(posedge ncs);
		ssp_dout <= 1'b0;
		send_cmd(make_conf(mode_hi_read_tx, 1'b0, 1'b0));
		wait_pins("full modulation", hi_mask, hi_mask);
		check_carrier("full modulation idle", 1'b0, 1'b0, 12);
		// A high data bit stops the carrier and only the probe pin shows it
		@(posedge ncs);
		ssp_dout <= 1'b1;
		repeat (12)
		begin
			@(negedge ncs);
			check_pins("full modulation data high", 11'b00000000001, pin_vec());
		end
	endtask

	task automatic test_shallow_mod();
		cmd_word_u w;
		send_cmd(make_conf(mode_hi_read_tx, 1'b0, 1'b1));
		wait_pins("shallow modulation", oe1_mask, oe1_mask);
		check_carrier("shallow modulation", 1'b1, 1'b1, 12);
		// Unknown opcode carrying a mode_off payload
		w = make_conf(mode_off, 1'b0, 1'b0);
		w.conf.opcode = 4'd5;
		send_cmd(w);
		check_carrier("ignored opcode", 1'b1, 1'b1, 12);
		send_cmd(make_conf(mode_off, 1'b0, 1'b0));
		wait_pins("mode off", oe1_mask, 11'b0);
		repeat (12)
		begin
			@(negedge ncs);
			check_pins("mode off", 11'b0, pin_vec());
		end
	endtask

	initial
	begin
		rnd = $urandom(16471);
		reset = 1'b1;
		spi_clk = 1'b0;
		spi_sel_n = 1'b1;
		mosi = 1'b0;
		adc_d = 8'h00;
		ssp_dout = 1'b0;
		repeat (3) @(posedge ncs);
		reset <= 1'b0;
		test_after_reset();
		test_lo_sampling();
		test_divisor_change();
		test_full_mod();
		test_shallow_mod();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== fpga.f ====
+incdir+verilog
verilog/fpga_pkg.sv
verilog/mode_pins_if.sv
verilog/spi_conf_rx.sv
verilog/lo_read.sv
verilog/hi_read_tx.sv
verilog/mode_mux.sv
verilog/fpga.sv
dv/fpga_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the fpga testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -f fpga.f --top-module fpga_tb -Mdir obj_dir -o fpga_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fpga_tb_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"

# The log decides the result
if grep -q "sim failed" "$log_file"; then
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

exit 0
